/* verilog/csr_map_pkg.sv */
// ====================
// machine CSR address map, reset values and mstatus layout
// imported by the CSR register file and the cycle timer
// ====================
`default_nettype none

package csr_map_pkg;

	// machine trap setup and handling
	localparam logic [11:0] csr_mstatus_addr = 12'h300;
	localparam logic [11:0] csr_mie_addr = 12'h304;
	localparam logic [11:0] csr_mtvec_addr = 12'h305;
	localparam logic [11:0] csr_mepc_addr = 12'h341;
	localparam logic [11:0] csr_mcause_addr = 12'h342;

	// counters, low half only on rv32
	localparam logic [11:0] csr_mcycle_addr = 12'hB00;

	// read-only machine info
	localparam logic [11:0] csr_mvendorid_addr = 12'hF11;
	localparam logic [11:0] csr_marchid_addr = 12'hF12;

	// custom read/write space, timer compare
	localparam logic [11:0] csr_mtimecmp_addr = 12'h7C0;

	// mpp already holds machine mode out of reset
	localparam logic [31:0] mstatus_reset = 32'h0000_1800;
	localparam logic [31:0] mvendorid_value = 32'h7973_7978;
	localparam logic [31:0] marchid_value = 32'd23060025;

	// compare parked at the top so no interrupt after reset
	localparam logic [31:0] mtimecmp_reset = 32'hFFFF_FFFF;

	// machine privilege encoding
	localparam logic [1:0] mpp_machine = 2'b11;

	// timer enable position inside mie
	localparam int mie_mtie_bit = 7;

	// mstatus bit layout, msb first
	typedef struct packed {
		logic [18:0] rsvd_hi;
		logic [1:0] mpp;
		logic [2:0] rsvd_mid;
		logic mpie;
		logic [2:0] rsvd_lo;
		logic mie;
		logic [2:0] rsvd_bot;
	} mstatus_fields_t;

	// csr instructions see the raw word, traps see the fields
	typedef union packed {
		logic [31:0] word;
		mstatus_fields_t f;
	} mstatus_word_u;

endpackage

`default_nettype wire

/* verilog/sys_op_pkg.sv */
// ====================
// system operation codes, trap causes and the
// request, redirect and trap command structs of the csr unit
// ====================
`default_nettype none

package sys_op_pkg;

	// decoded system instruction class from the core
	typedef enum logic [2:0] {
		op_none = 3'd0,
		op_csrrw = 3'd1,
		op_csrrs = 3'd2,
		op_csrrc = 3'd3,
		op_ecall = 3'd4,
		op_mret = 3'd5
	} sys_op_e;

	// mcause values
	localparam logic [31:0] cause_ecall_m = 32'd11;
	// interrupt flag in bit 31, machine timer code 7
	localparam logic [31:0] cause_timer_irq = 32'h8000_0007;

	// one-cycle strobe from the core, 80 bits
	typedef struct packed {
		logic valid;
		sys_op_e op;
		logic [11:0] addr;
		logic [31:0] wdata;
		logic [31:0] pc;
	} sys_req_t;

	// fetch redirect back to the core
	typedef struct packed {
		logic valid;
		logic [31:0] target;
	} redirect_t;

	// sequencer to register file
	typedef struct packed {
		logic enter;
		logic leave;
		logic [31:0] cause;
		logic [31:0] epc;
	} trap_cmd_t;

endpackage

`default_nettype wire

/* verilog/cycle_timer.sv */
// ====================
// free-running mcycle and mtimecmp compare
// drives the registered machine timer interrupt level
// ====================
`default_nettype none

module cycle_timer import csr_map_pkg::*; (
	input logic clock,
	input logic reset,
	input logic mcycle_we_i,
	input logic mtimecmp_we_i,
	input logic [31:0] wdata_i,
	output logic [31:0] mcycle_o,
	output logic [31:0] mtimecmp_o,
	output logic timer_irq_o
);

	logic [31:0] mcycle_q;
	logic [31:0] mtimecmp_q;
	logic irq_q;

	// counts every cycle, a write takes over at the next edge
	always_ff @(posedge clock) begin
		if (reset) begin
			mcycle_q <= '0;
		end else if (mcycle_we_i) begin
			mcycle_q <= wdata_i;
		end else begin
			mcycle_q <= mcycle_q + 32'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mtimecmp_q <= mtimecmp_reset;
		end else if (mtimecmp_we_i) begin
			mtimecmp_q <= wdata_i;
		end
	end

	// level stays up while counter is at or past compare
	always_ff @(posedge clock) begin
		if (reset) begin
			irq_q <= 1'b0;
		end else begin
			irq_q <= (mcycle_q >= mtimecmp_q);
		end
	end

	assign mcycle_o = mcycle_q;
	assign mtimecmp_o = mtimecmp_q;
	assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

/* verilog/csr_file.sv */
// ====================
// architectural machine CSRs with read mux and csrrw/rs/rc
// trap entry and return update mstatus, mepc and mcause
// ====================
`default_nettype none

module csr_file import csr_map_pkg::*, sys_op_pkg::*; (
	input logic clock,
	input logic reset,
	input sys_req_t req_i,
	input trap_cmd_t trap_cmd_i,
	input logic [31:0] mcycle_i,
	input logic [31:0] mtimecmp_i,
	output logic [31:0] rdata_o,
	output logic [31:0] mtvec_o,
	output logic [31:0] mepc_o,
	output logic irq_enable_o,
	output mstatus_word_u mstatus_o,
	output logic mcycle_we_o,
	output logic mtimecmp_we_o,
	output logic [31:0] timer_wdata_o
);

	mstatus_word_u mstatus_q;
	logic mtie_q;
	logic [31:0] mtvec_q;
	logic [31:0] mepc_q;
	logic [31:0] mcause_q;
	logic [31:0] mie_word;
	logic [31:0] old_value;
	logic [31:0] new_value;
	logic is_csr_op;
	logic src_zero;
	logic write_en;
	logic hit_mstatus;
	logic hit_mie;
	logic hit_mtvec;
	logic hit_mepc;
	logic hit_mcause;
	logic hit_mcycle;
	logic hit_mtimecmp;

	// only mtie is implemented in mie
	always_comb begin
		mie_word = '0;
		mie_word[mie_mtie_bit] = mtie_q;
	end

	// read mux, unmapped addresses give zero
	always_comb begin
		case (req_i.addr)
			csr_mstatus_addr: old_value = mstatus_q.word;
			csr_mie_addr: old_value = mie_word;
			csr_mtvec_addr: old_value = mtvec_q;
			csr_mepc_addr: old_value = mepc_q;
			csr_mcause_addr: old_value = mcause_q;
			csr_mcycle_addr: old_value = mcycle_i;
			csr_mtimecmp_addr: old_value = mtimecmp_i;
			csr_mvendorid_addr: old_value = mvendorid_value;
			csr_marchid_addr: old_value = marchid_value;
			default: old_value = '0;
		endcase
	end

	// old value goes back in the request cycle
	assign rdata_o = old_value;

	// write strobes, read-only ids have none
	assign hit_mstatus = (req_i.addr == csr_mstatus_addr);
	assign hit_mie = (req_i.addr == csr_mie_addr);
	assign hit_mtvec = (req_i.addr == csr_mtvec_addr);
	assign hit_mepc = (req_i.addr == csr_mepc_addr);
	assign hit_mcause = (req_i.addr == csr_mcause_addr);
	assign hit_mcycle = (req_i.addr == csr_mcycle_addr);
	assign hit_mtimecmp = (req_i.addr == csr_mtimecmp_addr);

	// read-modify-write value
	always_comb begin
		case (req_i.op)
			op_csrrw: new_value = req_i.wdata;
			op_csrrs: new_value = old_value | req_i.wdata;
			op_csrrc: new_value = old_value & ~req_i.wdata;
			default: new_value = old_value;
		endcase
	end

	assign is_csr_op = req_i.valid && (req_i.op inside {op_csrrw, op_csrrs, op_csrrc});
	// set/clear with a zero mask is a pure read
	assign src_zero = (req_i.op != op_csrrw) && (req_i.wdata == '0);
	assign write_en = is_csr_op && !src_zero;

	// counter and compare live in the timer
	assign mcycle_we_o = write_en && hit_mcycle;
	assign mtimecmp_we_o = write_en && hit_mtimecmp;
	assign timer_wdata_o = new_value;

	always_ff @(posedge clock) begin
		if (reset) begin
			mstatus_q.word <= mstatus_reset;
			mtie_q <= 1'b0;
			mtvec_q <= '0;
			mepc_q <= '0;
			mcause_q <= '0;
		end else if (trap_cmd_i.enter) begin
			// save context, stack the enable
			mepc_q <= trap_cmd_i.epc;
			mcause_q <= trap_cmd_i.cause;
			mstatus_q.f.mpie <= mstatus_q.f.mie;
			mstatus_q.f.mie <= 1'b0;
			mstatus_q.f.mpp <= mpp_machine;
		end else if (trap_cmd_i.leave) begin
			// pop the enable back
			mstatus_q.f.mie <= mstatus_q.f.mpie;
			mstatus_q.f.mpie <= 1'b1;
		end else if (write_en) begin
			if (hit_mstatus) begin
				mstatus_q.word <= new_value;
			end
			if (hit_mie) begin
				mtie_q <= new_value[mie_mtie_bit];
			end
			// direct mode only, mode bits read as zero
			if (hit_mtvec) begin
				mtvec_q <= {new_value[31:2], 2'b00};
			end
			if (hit_mepc) begin
				mepc_q <= new_value;
			end
			if (hit_mcause) begin
				mcause_q <= new_value;
			end
		end
	end

	// toward the sequencer
	assign mtvec_o = mtvec_q;
	assign mepc_o = mepc_q;
	assign irq_enable_o = mstatus_q.f.mie && mtie_q;
	assign mstatus_o = mstatus_q;

endmodule

`default_nettype wire

/* verilog/trap_sequencer.sv */
// ====================
// orders trap entry, mret and timer interrupt acceptance
// one busy cycle carries the redirect and the trap command
// ====================
`default_nettype none

module trap_sequencer import sys_op_pkg::*; (
	input logic clock,
	input logic reset,
	input sys_req_t req_i,
	input logic [31:0] pc_i,
	input logic timer_irq_i,
	input logic irq_enable_i,
	input logic [31:0] mtvec_i,
	input logic [31:0] mepc_i,
	output trap_cmd_t trap_cmd_o,
	output redirect_t redirect_o,
	output logic busy_o
);

	typedef enum logic [1:0] {
		st_idle,
		st_enter,
		st_leave
	} seq_state_e;

	seq_state_e state_q;
	seq_state_e state_d;
	logic [31:0] cause_q;
	logic [31:0] epc_q;
	logic [31:0] target_q;
	logic take_ecall;
	logic take_mret;
	logic take_irq;

	assign take_ecall = req_i.valid && (req_i.op == op_ecall);
	assign take_mret = req_i.valid && (req_i.op == op_mret);
	// interrupt waits out any valid request, so ecall wins
	assign take_irq = !req_i.valid && timer_irq_i && irq_enable_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (take_ecall || take_irq) begin
					state_d = st_enter;
				end else if (take_mret) begin
					state_d = st_leave;
				end
			end
			// single busy cycle, then back
			st_enter: state_d = st_idle;
			st_leave: state_d = st_idle;
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= st_idle;
		end else begin
			state_q <= state_d;
		end
	end

	// capture context when leaving idle
	always_ff @(posedge clock) begin
		if (state_q == st_idle && (take_ecall || take_mret || take_irq)) begin
			cause_q <= take_ecall ? cause_ecall_m : cause_timer_irq;
			// interrupt resumes at the next pc to retire
			epc_q <= take_ecall ? req_i.pc : pc_i;
			target_q <= take_mret ? mepc_i : mtvec_i;
		end
	end

	assign trap_cmd_o.enter = (state_q == st_enter);
	assign trap_cmd_o.leave = (state_q == st_leave);
	assign trap_cmd_o.cause = cause_q;
	assign trap_cmd_o.epc = epc_q;

	assign redirect_o.valid = (state_q != st_idle);
	assign redirect_o.target = target_q;
	assign busy_o = (state_q != st_idle);

endmodule

`default_nettype wire

/* verilog/csr_unit.sv */
// ====================
// machine system register block, top level
// core sends strobes on req_i and takes the redirect
// ====================
`default_nettype none

module csr_unit import sys_op_pkg::*; (
	input logic clock,
	input logic reset,
	input sys_req_t req_i,
	input logic [31:0] pc_i,
	output logic [31:0] rdata_o,
	output redirect_t redirect_o,
	output logic busy_o
);

	trap_cmd_t trap_cmd;
	logic [31:0] mtvec;
	logic [31:0] mepc;
	logic irq_enable;
	logic mcycle_we;
	logic mtimecmp_we;
	logic [31:0] timer_wdata;
	logic [31:0] mcycle;
	logic [31:0] mtimecmp;
	logic timer_irq;

	csr_file csr_file_inst (
		.clock(clock),
		.reset(reset),
		.req_i(req_i),
		.trap_cmd_i(trap_cmd),
		.mcycle_i(mcycle),
		.mtimecmp_i(mtimecmp),
		.rdata_o(rdata_o),
		.mtvec_o(mtvec),
		.mepc_o(mepc),
		.irq_enable_o(irq_enable),
		// full status word only for probing
		.mstatus_o(),
		.mcycle_we_o(mcycle_we),
		.mtimecmp_we_o(mtimecmp_we),
		.timer_wdata_o(timer_wdata)
	);

	trap_sequencer trap_sequencer_inst (
		.clock(clock),
		.reset(reset),
		.req_i(req_i),
		.pc_i(pc_i),
		.timer_irq_i(timer_irq),
		.irq_enable_i(irq_enable),
		.mtvec_i(mtvec),
		.mepc_i(mepc),
		.trap_cmd_o(trap_cmd),
		.redirect_o(redirect_o),
		.busy_o(busy_o)
	);

	cycle_timer cycle_timer_inst (
		.clock(clock),
		.reset(reset),
		.mcycle_we_i(mcycle_we),
		.mtimecmp_we_i(mtimecmp_we),
		.wdata_i(timer_wdata),
		.mcycle_o(mcycle),
		.mtimecmp_o(mtimecmp),
		.timer_irq_o(timer_irq)
	);

endmodule

`default_nettype wire

/* sim/csr_unit_tb.sv */
// ====================
// testbench for the csr unit, replays sim/csr_unit_vectors.txt
// checks read data, redirect and busy for every vector line
// ====================
`default_nettype none

module csr_unit_tb import sys_op_pkg::*;;

	logic clock;
	logic reset;
	sys_req_t req;
	logic [31:0] pc_in;
	logic [31:0] rdata;
	redirect_t redirect;
	logic busy;

	// bookkeeping per test number and overall
	int cur_test;
	int test_errs;
	int err_count;
	int tests_ok;
	int tests_bad;

	csr_unit csr_unit_inst (
		.clock(clock),
		.reset(reset),
		.req_i(req),
		.pc_i(pc_in),
		.rdata_o(rdata),
		.redirect_o(redirect),
		.busy_o(busy)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#5 clock = ~clock;
		end
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: test %0d %s got %h expected %h", $time, cur_test, what, got, exp);
			err_count++;
			test_errs++;
		end
	endtask

	// one result line per test number
	task automatic finish_test();
		if (test_errs == 0) begin
			$display("test %0d ok", cur_test);
			tests_ok++;
		end else begin
			$display("test %0d: %0d mismatches", cur_test, test_errs);
			tests_bad++;
		end
		test_errs = 0;
	endtask

	// request cycle, then the cycle where a redirect would show
	task automatic run_vector(input int op, input logic [31:0] addr, input logic [31:0] wdata,
			input logic [31:0] pc, input logic [31:0] exp_rdata, input int exp_redir,
			input logic [31:0] exp_target, input int flag);
		int cycles;
		logic in_range;
		@(posedge clock);
		req.valid <= (op != 0);
		req.op <= sys_op_e'(op[2:0]);
		req.addr <= addr[11:0];
		req.wdata <= wdata;
		req.pc <= pc;
		pc_in <= pc;
		@(negedge clock);
		// old value is combinational in the request cycle
		if (flag == 2) begin
			in_range = (rdata >= exp_rdata) && ((rdata - exp_rdata) < 32'd5);
			check_value({31'b0, in_range}, 32'd1, "rdata not within 5 above floor");
		end else if (flag != 3) begin
			check_value(rdata, exp_rdata, "rdata");
		end
		if (flag == 1) begin
			// interrupt latency varies, poll the redirect
			cycles = 0;
			while (!redirect.valid && cycles < 200) begin
				@(posedge clock);
				@(negedge clock);
				cycles++;
			end
			if (!redirect.valid) begin
				$display("timeout: no redirect within 200 cycles in test %0d", cur_test);
				err_count++;
				test_errs++;
			end
		end else begin
			check_value({31'b0, redirect.valid}, 32'd0, "redirect before request taken");
			@(posedge clock);
			req.valid <= 1'b0;
			@(negedge clock);
		end
		check_value({31'b0, redirect.valid}, exp_redir, "redirect valid");
		check_value({31'b0, busy}, exp_redir, "busy");
		if (exp_redir != 0) begin
			check_value(redirect.target, exp_target, "redirect target");
		end
	endtask

	initial begin
		int fd;
		int n;
		int done;
		int t_num;
		int op;
		int redir;
		int flag;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] pc;
		logic [31:0] exp_rdata;
		logic [31:0] exp_target;
		logic [8*200-1:0] line;
		// quiet bus while in reset
		reset <= 1'b1;
		req <= '0;
		pc_in <= '0;
		cur_test = 0;
		test_errs = 0;
		err_count = 0;
		tests_ok = 0;
		tests_bad = 0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		fd = $fopen("sim/csr_unit_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file sim/csr_unit_vectors.txt");
			err_count++;
		end else begin
			done = 0;
			while (done == 0) begin
				line = '0;
				if ($fgets(line, fd) == 0) begin
					done = 1;
				end else begin
					n = $sscanf(line, "%d %d %h %h %h %h %d %h %d", t_num, op, addr,
						wdata, pc, exp_rdata, redir, exp_target, flag);
					// comment and blank lines give fewer fields
					if (n == 9) begin
						if (t_num != cur_test) begin
							if (cur_test != 0) begin
								finish_test();
							end
							cur_test = t_num;
						end
						run_vector(op, addr, wdata, pc, exp_rdata, redir, exp_target, flag);
					end
				end
			end
			$fclose(fd);
			if (cur_test != 0) begin
				finish_test();
			end
		end
		$display("summary: %0d tests ok, %0d tests with errors, %0d errors in all",
			tests_ok, tests_bad, err_count);
		if (err_count == 0 && tests_bad == 0 && tests_ok > 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/csr_unit_vectors.txt */
# test op addr wdata pc exp_rdata exp_redirect exp_target flag (addr, data and pc in hex)
# op 0 none 1 csrrw 2 csrrs 3 csrrc 4 ecall 5 mret, flag 0 exact 1 wait redirect 2 rdata floor 3 unchecked
1 2 300 00000000 00000000 00001800 0 00000000 0
1 2 F11 00000000 00000000 79737978 0 00000000 0
1 2 F12 00000000 00000000 015FDE39 0 00000000 0
1 1 F11 12345678 00000000 79737978 0 00000000 0
1 2 F11 00000000 00000000 79737978 0 00000000 0
1 1 7FF DEADBEEF 00000000 00000000 0 00000000 0
1 2 7FF 00000000 00000000 00000000 0 00000000 0
2 1 305 00000100 00000000 00000000 0 00000000 0
2 2 305 00000010 00000000 00000100 0 00000000 0
2 3 305 00000100 00000000 00000110 0 00000000 0
2 2 305 00000000 00000000 00000010 0 00000000 0
2 1 305 00000200 00000000 00000010 0 00000000 0
2 2 304 00000080 00000000 00000000 0 00000000 0
2 2 304 00000000 00000000 00000080 0 00000000 0
2 3 304 00000080 00000000 00000080 0 00000000 0
2 2 304 00000000 00000000 00000000 0 00000000 0
3 2 300 00000008 00000000 00001800 0 00000000 0
3 4 000 00000000 00000440 00000000 1 00000200 0
3 2 341 00000000 00000000 00000440 0 00000000 0
3 2 342 00000000 00000000 0000000B 0 00000000 0
3 2 300 00000000 00000000 00001880 0 00000000 0
4 1 341 00000444 00000000 00000440 0 00000000 0
4 5 000 00000000 00000000 00000000 1 00000444 0
4 2 300 00000000 00000000 00001888 0 00000000 0
5 3 300 00000008 00000000 00001888 0 00000000 0
5 2 304 00000080 00000000 00000000 0 00000000 0
5 1 B00 00001000 00000000 00000000 0 00000000 3
5 2 B00 00000000 00000000 00001000 0 00000000 2
5 1 7C0 00001006 00000000 FFFFFFFF 0 00000000 0
5 2 7C0 00000000 00000000 00001006 0 00000000 0
5 2 342 00000000 00000000 0000000B 0 00000000 0
5 2 300 00000000 00000000 00001880 0 00000000 0
5 2 300 00000008 00000700 00001880 0 00000000 0
5 0 000 00000000 00000700 00000000 1 00000200 1
5 2 341 00000000 00000000 00000700 0 00000000 0
5 2 342 00000000 00000000 80000007 0 00000000 0
5 2 300 00000000 00000000 00001880 0 00000000 0
6 1 B00 00050000 00000000 00000000 0 00000000 3
6 2 B00 00000000 00000000 00050000 0 00000000 2
6 1 B00 ABCD0000 00000000 00050000 0 00000000 2
6 2 B00 00000000 00000000 ABCD0000 0 00000000 2

/* vlog.f */
verilog/csr_map_pkg.sv
verilog/sys_op_pkg.sv
verilog/cycle_timer.sv
verilog/csr_file.sv
verilog/trap_sequencer.sv
verilog/csr_unit.sv
sim/csr_unit_tb.sv

/* Makefile */
# Verilator build for the csr unit testbench

TOOL := verilator
FLAGS := --binary --timing
LINT_FLAGS := --lint-only --timing
TOP := csr_unit_tb
RTL_TOP := csr_unit
FILELIST := vlog.f
OBJ_DIR := obj_dir
PASS_MSG := test passed

.PHONY: all lint sim clean

all: sim

# lint the whole tree through the testbench top
lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# build, run, and fail unless the pass line shows up
sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
